//--- ev_geom_pkg.sv
`default_nettype none

package ev_geom_pkg;

    // Random-bit BRAM, 64 bits by 16384 words
    localparam int EV_WORD_W = 64;
    localparam int EV_ADDR_W = 14;

    // One session is 32 rounds of 512 BRAM words
    localparam int EV_ROUND_COUNT     = 32;
    localparam int EV_WORDS_PER_ROUND = 512;

    localparam int ROUND_W = 8;  // Round index, also the header round field
    localparam int SLOT_W  = 11; // Header slot plus 1024 half-word slots

    // Slot cycle to FIFO write
    //   slot -> BRAM read -> output register -> FIFO port register
    localparam int PIPE_LATENCY = 3;

endpackage

`default_nettype wire

//--- a2b_pkt_pkg.sv
`default_nettype none

package a2b_pkt_pkg;

    localparam int LINK_W = 32; // A2B FIFO word

    localparam logic [3:0] PKT_TYPE_EV_RANDOMBIT = 4'h1;

    localparam int PKT_LEN_W = 12;

    // Header plus 512 words sent as 1024 halves
    localparam int EV_PKT_WORDS    = 1025;
    localparam int SLOTS_PER_ROUND = EV_PKT_WORDS; // One FIFO word per slot

    // First word of every packet
    typedef struct packed {
        logic [3:0]           pkt_type;
        logic [PKT_LEN_W-1:0] pkt_len;  // Words in packet, header included
        logic [7:0]           rsvd;     // Always zero
        logic [7:0]           round;
    } a2b_hdr_t;

endpackage

`default_nettype wire

//--- round_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface round_ctrl_if
    import ev_geom_pkg::*;
();

    logic               slot_clear; // Restart slot count at round start
    logic               slot_en;    // One word slot this cycle
    logic               round_adv;  // Step to next round
    logic [SLOT_W-1:0]  slot;
    logic [ROUND_W-1:0] round;
    logic               last_slot;
    logic               last_round;

    modport fsm (
        output slot_clear,
        output slot_en,
        output round_adv,
        input  last_slot,
        input  last_round
    );

    modport counter (
        input  slot_clear,
        input  slot_en,
        input  round_adv,
        output slot,
        output round,
        output last_slot,
        output last_round
    );

    // Read-only view for the BRAM side
    modport data (
        input slot_en,
        input slot,
        input round
    );

endinterface

`default_nettype wire

//--- ev_round_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module ev_round_fsm
    import ev_geom_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         start_er,
    input  logic         a2b_empty,
    output logic         finish_er,
    output logic         busy,
    round_ctrl_if.fsm    ctrl
);

    typedef enum logic [2:0] {
        IDLE,
        ROUND_WAIT,
        ROUND_SEND,
        ROUND_END,
        DRAIN,
        DONE
    } state_t;

    state_t     state;
    state_t     state_nxt;
    logic [1:0] drain_cnt;  // Cycles since the last slot, saturates
    logic       pipe_idle;

    // Nothing left in the read and write pipeline
    assign pipe_idle = (drain_cnt == 2'(PIPE_LATENCY));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            drain_cnt <= 2'(PIPE_LATENCY);
        end else if (ctrl.slot_en) begin
            drain_cnt <= '0;
        end else if (!pipe_idle) begin
            drain_cnt <= drain_cnt + 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt       = state;
        ctrl.slot_clear = 1'b0;
        ctrl.slot_en    = 1'b0;
        ctrl.round_adv  = 1'b0;
        case (state)
            IDLE: begin
                if (start_er) begin
                    state_nxt = ROUND_WAIT;
                end
            end
            ROUND_WAIT: begin
                // Previous packet fully written and consumed
                if (a2b_empty && pipe_idle) begin
                    ctrl.slot_clear = 1'b1;
                    state_nxt       = ROUND_SEND;
                end
            end
            ROUND_SEND: begin
                ctrl.slot_en = 1'b1;
                if (ctrl.last_slot) begin
                    state_nxt = ROUND_END;
                end
            end
            ROUND_END: begin
                ctrl.round_adv = 1'b1;
                state_nxt      = ctrl.last_round ? DRAIN : ROUND_WAIT;
            end
            DRAIN: begin
                if (pipe_idle) begin
                    state_nxt = DONE;
                end
            end
            DONE:    state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    assign finish_er = (state == DONE);
    assign busy      = (state != IDLE) && (state != DONE); // Drops with finish

endmodule

`default_nettype wire

//--- ev_slot_counter.sv
`timescale 1ns/1ps
`default_nettype none

module ev_slot_counter
    import ev_geom_pkg::*;
    import a2b_pkt_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    round_ctrl_if.counter ctrl
);

    assign ctrl.last_slot  = (ctrl.slot == SLOT_W'(SLOTS_PER_ROUND - 1));
    assign ctrl.last_round = (ctrl.round == ROUND_W'(EV_ROUND_COUNT - 1));

    // Slot 0 is the header, 1 to 1024 carry data halves
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl.slot <= '0;
        end else if (ctrl.slot_clear) begin
            ctrl.slot <= '0;
        end else if (ctrl.slot_en) begin
            if (ctrl.last_slot) begin
                ctrl.slot <= '0;
            end else begin
                ctrl.slot <= ctrl.slot + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl.round <= '0;
        end else if (ctrl.round_adv) begin
            // Wrap so the next session starts at round 0
            if (ctrl.last_round) begin
                ctrl.round <= '0;
            end else begin
                ctrl.round <= ctrl.round + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- ev_bram_reader.sv
`timescale 1ns/1ps
`default_nettype none

module ev_bram_reader
    import ev_geom_pkg::*;
    import a2b_pkt_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    output logic [EV_ADDR_W-1:0] ev_bram_addr,
    output logic                 ev_bram_en,
    input  logic [EV_WORD_W-1:0] ev_bram_dout,
    output logic [LINK_W-1:0]    data_word,
    output logic                 data_valid,
    output logic                 header_valid,
    output logic [ROUND_W-1:0]   hdr_round,
    round_ctrl_if.data           ctrl
);

    logic [SLOT_W-1:0]                     slot_m1;
    logic [$clog2(EV_WORDS_PER_ROUND)-1:0] word_idx;
    logic [EV_WORD_W-1:0]                  dout_q;
    logic [1:0]                            en_d;
    logic [1:0]                            hdr_d;
    logic [1:0]                            upper_d;
    logic [ROUND_W-1:0]                    round_d1;
    logic [ROUND_W-1:0]                    round_d2;

    // Two slots per BRAM word so slot 1 maps to word 0
    assign slot_m1  = ctrl.slot - 1'b1;
    assign word_idx = slot_m1[$clog2(EV_WORDS_PER_ROUND):1];

    assign ev_bram_addr = EV_ADDR_W'(ctrl.round) * EV_ADDR_W'(EV_WORDS_PER_ROUND)
                        + EV_ADDR_W'(word_idx);
    assign ev_bram_en   = ctrl.slot_en;

    always_ff @(posedge clk) begin
        dout_q <= ev_bram_dout; // Second read stage
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            en_d <= '0;
        end else begin
            en_d <= {en_d[0], ctrl.slot_en};
        end
    end

    // Slot attributes follow the BRAM data
    always_ff @(posedge clk) begin
        hdr_d    <= {hdr_d[0], (ctrl.slot == '0)};
        upper_d  <= {upper_d[0], ctrl.slot[0]}; // Odd slot takes the upper half
        round_d1 <= ctrl.round;
        round_d2 <= round_d1;
    end

    assign header_valid = en_d[1] && hdr_d[1];
    assign data_valid   = en_d[1] && !hdr_d[1];
    assign hdr_round    = round_d2;
    assign data_word    = upper_d[1] ? dout_q[EV_WORD_W-1:LINK_W] : dout_q[LINK_W-1:0];

endmodule

`default_nettype wire

//--- a2b_packet_writer.sv
`timescale 1ns/1ps
`default_nettype none

module a2b_packet_writer
    import ev_geom_pkg::*;
    import a2b_pkt_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic [LINK_W-1:0]  data_word,
    input  logic               data_valid,
    input  logic               header_valid,
    input  logic [ROUND_W-1:0] hdr_round,
    output logic               a2b_wr_en,
    output logic [LINK_W-1:0]  a2b_wr_din
);

    a2b_hdr_t hdr;

    assign hdr = '{
        pkt_type: PKT_TYPE_EV_RANDOMBIT,
        pkt_len:  PKT_LEN_W'(EV_PKT_WORDS),
        rsvd:     '0,
        round:    hdr_round
    };

    // Third pipeline stage, straight onto the FIFO port
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a2b_wr_en <= 1'b0;
        end else begin
            a2b_wr_en <= header_valid || data_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (header_valid) begin
            a2b_wr_din <= hdr;
        end else if (data_valid) begin
            a2b_wr_din <= data_word;
        end
    end

endmodule

`default_nettype wire

//--- alice_er_top.sv
`timescale 1ns/1ps
`default_nettype none

module alice_er_top
    import ev_geom_pkg::*;
    import a2b_pkt_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start_er,
    output logic                 finish_er,
    output logic                 busy,
    output logic [EV_ADDR_W-1:0] ev_bram_addr,  // Random-bit BRAM read port
    output logic                 ev_bram_en,
    input  logic [EV_WORD_W-1:0] ev_bram_dout,
    input  logic                 a2b_empty,     // A2B FIFO write side
    output logic                 a2b_wr_en,
    output logic [LINK_W-1:0]    a2b_wr_din
);

    logic [LINK_W-1:0]  data_word;
    logic               data_valid;
    logic               header_valid;
    logic [ROUND_W-1:0] hdr_round;

    round_ctrl_if ctrl ();

    ev_round_fsm i_ev_round_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_er  (start_er),
        .a2b_empty (a2b_empty),
        .finish_er (finish_er),
        .busy      (busy),
        .ctrl      (ctrl.fsm)
    );

    ev_slot_counter i_ev_slot_counter (
        .clk   (clk),
        .rst_n (rst_n),
        .ctrl  (ctrl.counter)
    );

    ev_bram_reader i_ev_bram_reader (
        .clk          (clk),
        .rst_n        (rst_n),
        .ev_bram_addr (ev_bram_addr),
        .ev_bram_en   (ev_bram_en),
        .ev_bram_dout (ev_bram_dout),
        .data_word    (data_word),
        .data_valid   (data_valid),
        .header_valid (header_valid),
        .hdr_round    (hdr_round),
        .ctrl         (ctrl.data)
    );

    a2b_packet_writer i_a2b_packet_writer (
        .clk          (clk),
        .rst_n        (rst_n),
        .data_word    (data_word),
        .data_valid   (data_valid),
        .header_valid (header_valid),
        .hdr_round    (hdr_round),
        .a2b_wr_en    (a2b_wr_en),
        .a2b_wr_din   (a2b_wr_din)
    );

endmodule

`default_nettype wire

//--- alice_er_tb_model.sv
`timescale 1ns/1ps
`default_nettype none

module alice_er_tb_model (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [13:0] bram_addr,
    input  logic        bram_en,
    output logic [63:0] bram_dout,
    input  logic        wr_en,
    output logic        empty,
    output logic [11:0] fifo_count
);

    logic [63:0] mem [0:16383]; // Random-bit BRAM contents
    integer      seed;
    logic [13:0] addr_q;
    logic        en_q;
    logic        wr_seen;
    logic [31:0] rnd;

    initial begin
        logic [31:0] hi;
        logic [31:0] lo;
        seed       = 32'h83df362d;
        bram_dout  = '0;
        empty      = 1'b1;
        fifo_count = '0;
        addr_q     = '0;
        en_q       = 1'b0;
        wr_seen    = 1'b0;
        for (int i = 0; i < 16384; i++) begin
            hi     = $random(seed);
            lo     = $random(seed);
            mem[i] = {hi, lo};
        end
    end

    // Sample the DUT at mid-cycle
    always @(negedge clk) begin
        addr_q  = bram_addr;
        en_q    = bram_en;
        wr_seen = wr_en;
    end

    always @(posedge clk) begin
        #1;
        if (en_q === 1'b1) begin
            bram_dout = mem[addr_q]; // One cycle read latency
        end
        rnd = $random(seed);
        if (!rst_n) begin
            fifo_count = '0;
        end else begin
            if (wr_seen === 1'b1) begin
                fifo_count = fifo_count + 12'd1;
            end
            // Reader side pops about three cycles in four
            if (fifo_count != '0 && rnd[1:0] != 2'b00) begin
                fifo_count = fifo_count - 12'd1;
            end
        end
        empty = (fifo_count == '0);
    end

endmodule

`default_nettype wire

//--- alice_er_tb.sv
`timescale 1ns/1ps
`default_nettype none

module alice_er_tb;

    localparam int ROUNDS         = 32;
    localparam int SLOTS          = 1025;   // Header plus 1024 halves
    localparam int TIMEOUT_CYCLES = 200000;

    logic        clk;
    logic        rst_n;
    logic        start_er;
    logic        finish_er;
    logic        busy;
    logic [13:0] ev_bram_addr;
    logic        ev_bram_en;
    logic [63:0] ev_bram_dout;
    logic        a2b_empty;
    logic        a2b_wr_en;
    logic [31:0] a2b_wr_din;
    logic [11:0] fifo_count;

    logic [31:0] exp_q [$];
    int          words_in_pkt = 0;
    int          pkt_cnt = 0;
    int          finish_cnt = 0;
    logic        prev_busy = 1'b0;

    alice_er_top i_alice_er_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_er     (start_er),
        .finish_er    (finish_er),
        .busy         (busy),
        .ev_bram_addr (ev_bram_addr),
        .ev_bram_en   (ev_bram_en),
        .ev_bram_dout (ev_bram_dout),
        .a2b_empty    (a2b_empty),
        .a2b_wr_en    (a2b_wr_en),
        .a2b_wr_din   (a2b_wr_din)
    );

    alice_er_tb_model i_tb_model (
        .clk        (clk),
        .rst_n      (rst_n),
        .bram_addr  (ev_bram_addr),
        .bram_en    (ev_bram_en),
        .bram_dout  (ev_bram_dout),
        .wr_en      (a2b_wr_en),
        .empty      (a2b_empty),
        .fifo_count (fifo_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_stop(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            fail_stop($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, actual, expected));
        end
    endtask

    // One session of packets for rounds 0 to 31
    function automatic void build_expected();
        logic [63:0] w;
        for (int r = 0; r < ROUNDS; r++) begin
            exp_q.push_back({4'h1, 12'd1025, 8'h00, 8'(r)}); // Header
            for (int s = 1; s < SLOTS; s++) begin
                w = i_tb_model.mem[r * 512 + (s - 1) / 2];
                exp_q.push_back((s % 2 == 1) ? w[63:32] : w[31:0]); // Upper half first
            end
        end
    endfunction

    always @(negedge clk) begin
        if (rst_n) begin
            if (a2b_wr_en) begin
                if (exp_q.size() == 0) begin
                    fail_stop("Write to the A2B FIFO when no word was expected");
                end else begin
                    if (words_in_pkt == 0) begin
                        check_value("fifo_count at header", fifo_count, 0);
                    end
                    check_value("a2b_wr_din", a2b_wr_din, exp_q.pop_front());
                    words_in_pkt = (words_in_pkt == SLOTS - 1) ? 0 : words_in_pkt + 1;
                    if (words_in_pkt == 0) begin
                        pkt_cnt++;
                    end
                end
            end else if (words_in_pkt != 0) begin
                fail_stop("Packet writes were not in consecutive cycles");
            end
            if (finish_er) begin
                if (exp_q.size() != 0) begin
                    fail_stop("finish_er came before the last packet word was written");
                end
                check_value("a2b_wr_en", a2b_wr_en, 0);
                check_value("busy", busy, 0);
                check_value("busy before finish_er", prev_busy, 1);
                finish_cnt++;
            end
            prev_busy = busy;
        end
    end

    task automatic pulse_start();
        @(posedge clk);
        #1 start_er = 1'b1;
        @(posedge clk);
        #1 start_er = 1'b0;
    endtask

    task automatic run_session(input bit start_while_busy);
        int base;
        int cycles;
        base    = finish_cnt;
        pkt_cnt = 0;
        build_expected();
        pulse_start();
        if (start_while_busy) begin
            repeat (300) @(posedge clk);
            @(negedge clk);
            check_value("busy", busy, 1);
            pulse_start(); // Must be ignored
        end
        cycles = 0;
        while (finish_cnt == base && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (finish_cnt == base) begin
            fail_stop("Timeout while waiting for finish_er");
        end else begin
            repeat (50) @(negedge clk);
            check_value("finish_er pulses", finish_cnt, base + 1);
            check_value("packet count", pkt_cnt, ROUNDS);
            check_value("busy", busy, 0);
        end
    endtask

    initial begin
        rst_n    = 1'b0;
        start_er = 1'b0;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        repeat (10) begin
            @(negedge clk);
            check_value("a2b_wr_en", a2b_wr_en, 0);
            check_value("finish_er", finish_er, 0);
            check_value("busy", busy, 0);
            check_value("ev_bram_en", ev_bram_en, 0);
        end
        run_session(1'b0);
        run_session(1'b1); // Second session restarts from round 0
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- alice_er_top.f
ev_geom_pkg.sv
a2b_pkt_pkg.sv
round_ctrl_if.sv
ev_round_fsm.sv
ev_slot_counter.sv
ev_bram_reader.sv
a2b_packet_writer.sv
alice_er_top.sv
alice_er_tb_model.sv
alice_er_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module alice_er_tb \
    -f alice_er_top.f -o alice_er_sim

./obj_dir/alice_er_sim | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
exit 0
